// File: proc.f
source/isa_pkg.sv
source/pipe_pkg.sv
source/pipe_latch.sv
source/fetch.sv
source/decode.sv
source/hazard_unit.sv
source/execute.sv
source/memory_stage.sv
source/proc.sv
testbench/proc_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Compile and run the processor testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module proc_tb \
   -f proc.f --Mdir obj_dir -o proc_tb_sim
if [ $? -ne 0 ]; then
   echo "Verilator compile failed"
   exit 1
fi

./obj_dir/proc_tb_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if grep -q "Test failures found" sim.log; then
   exit 1
fi
if ! grep -q "All tests passed!" sim.log; then
   echo "Simulation ended without a result"
   exit 1
fi
exit 0

// File: testbench/proc_tb.sv
// Testbench for the pipelined processor with directed and random programs and a reference model
`timescale 1ns/1ps
module proc_tb;

   localparam int max_words = 16;
   localparam int rand_runs = 6;
   localparam int directed_words = 48;
   localparam int cycle_limit = 20 * (directed_words + rand_runs * max_words) + 200;

   localparam logic [4:0] opc_halt = 5'b00000;
   localparam logic [4:0] opc_nop = 5'b00001;
   localparam logic [4:0] opc_j = 5'b00100;
   localparam logic [4:0] opc_jal = 5'b00110;
   localparam logic [4:0] opc_addi = 5'b01000;
   localparam logic [4:0] opc_subi = 5'b01001;
   localparam logic [4:0] opc_beqz = 5'b01100;
   localparam logic [4:0] opc_bnez = 5'b01101;
   localparam logic [4:0] opc_st = 5'b10000;
   localparam logic [4:0] opc_ld = 5'b10001;
   localparam logic [4:0] opc_alu = 5'b11011;

   logic clk;
   logic rst_n;
   logic prog_we;
   logic [7:0] prog_addr;
   logic [15:0] prog_data;
   logic retire_valid;
   logic [2:0] retire_reg;
   logic [15:0] retire_data;
   logic halted;
   logic err;

   logic [15:0] prog [256];
   logic [15:0] ref_mem [256];
   int prog_len;
   int exp_reg [64];
   logic [15:0] exp_val [64];
   int exp_count;
   int exp_idx;
   logic exp_err;
   int value_errors;
   int other_errors;
   int cycles;
   logic [31:0] lfsr;
   string cur_name;

   proc uut (
      .clk, .rst_n, .prog_we, .prog_addr, .prog_data,
      .retire_valid, .retire_reg, .retire_data, .halted, .err
   );

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   function automatic logic [15:0] enc_imm(input logic [4:0] op, input int rs, input int rt,
                                           input int imm);
      return {op, 3'(rs), 3'(rt), 5'(imm)};
   endfunction

   function automatic logic [15:0] enc_alu(input int rs, input int rt, input int rd,
                                           input int func);
      return {opc_alu, 3'(rs), 3'(rt), 3'(rd), 2'(func)};
   endfunction

   function automatic logic [15:0] enc_branch(input logic [4:0] op, input int rs, input int imm);
      return {op, 3'(rs), 8'(imm)};
   endfunction

   function automatic logic [15:0] enc_jump(input logic [4:0] op, input int imm);
      return {op, 11'(imm)};
   endfunction

   // Taps 32, 22, 2, 1
   function automatic logic next_bit();
      logic fb;
      fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      return fb;
   endfunction

   function automatic int rand_bits(input int n);
      int r;
      r = 0;
      for (int i = 0; i < n; i++) begin
         r = (r << 1) | int'(next_bit());
      end
      return r;
   endfunction

   // In-order execution of prog into the expected write list and err
   function automatic int run_reference();
      logic [15:0] regs [8];
      logic [15:0] pc;
      logic [15:0] instr;
      logic [15:0] addr;
      logic [15:0] val;
      logic [4:0] op;
      int rs;
      int rt;
      int wr_reg;
      int n;
      int steps;
      logic done;
      for (int i = 0; i < 8; i++) begin
         regs[i] = '0;
      end
      pc = '0;
      n = 0;
      steps = 0;
      done = 1'b0;
      exp_err = 1'b0;
      while (!done && steps < 100) begin
         instr = prog[pc[8:1]];
         op = instr[15:11];
         rs = int'(instr[10:8]);
         rt = int'(instr[7:5]);
         addr = regs[rs] + {{11{instr[4]}}, instr[4:0]};
         wr_reg = -1;
         val = '0;
         steps++;
         pc = pc + 16'd2;
         case (op)
            opc_halt: done = 1'b1;
            opc_nop: begin
            end
            opc_addi: begin
               wr_reg = rt;
               val = addr;
            end
            opc_subi: begin
               wr_reg = rt;
               val = regs[rs] - {{11{instr[4]}}, instr[4:0]};
            end
            opc_ld: begin
               // Odd address still reads the word and only err reports it
               exp_err = exp_err | addr[0];
               wr_reg = rt;
               val = ref_mem[addr[8:1]];
            end
            opc_st: begin
               if (addr[0]) begin
                  exp_err = 1'b1;
               end else begin
                  ref_mem[addr[8:1]] = regs[rt];
               end
            end
            opc_beqz, opc_bnez: begin
               if ((regs[rs] == 16'd0) == (op == opc_beqz)) begin
                  pc = pc + {{8{instr[7]}}, instr[7:0]};
               end
            end
            opc_j, opc_jal: begin
               if (op == opc_jal) begin
                  wr_reg = 7;
                  val = pc;
               end
               pc = pc + {{5{instr[10]}}, instr[10:0]};
            end
            opc_alu: begin
               wr_reg = int'(instr[4:2]);
               case (instr[1:0])
                  2'd0: val = regs[rs] + regs[rt];
                  2'd1: val = regs[rs] - regs[rt];
                  2'd2: val = regs[rs] ^ regs[rt];
                  default: val = regs[rs] & regs[rt];
               endcase
            end
            default: exp_err = 1'b1;
         endcase
         if (wr_reg >= 0) begin
            regs[wr_reg] = val;
            exp_reg[n] = wr_reg;
            exp_val[n] = val;
            n++;
         end
      end
      return n;
   endfunction

   task automatic append_word(input logic [15:0] w);
      prog[prog_len] = w;
      prog_len++;
   endtask

   // r0 stays zero, so memory accesses use r0 as base
   task automatic build_random();
      int kind;
      prog_len = 0;
      for (int i = 0; i < max_words - 1; i++) begin
         kind = rand_bits(3);
         case (kind)
            0, 1: append_word(enc_alu(rand_bits(3) % 7, rand_bits(3) % 7,
                                      rand_bits(3) % 6 + 1, rand_bits(2)));
            2: append_word(enc_imm(opc_addi, rand_bits(3) % 7, rand_bits(3) % 6 + 1,
                                   rand_bits(5)));
            3: append_word(enc_imm(opc_subi, rand_bits(3) % 7, rand_bits(3) % 6 + 1,
                                   rand_bits(5)));
            4: append_word(enc_imm(opc_st, 0, rand_bits(3) % 7, rand_bits(3) * 2));
            5: append_word(enc_imm(opc_ld, 0, rand_bits(3) % 6 + 1, rand_bits(3) * 2));
            default: begin
               if (i + 3 <= max_words - 1) begin
                  append_word(enc_branch(rand_bits(1) ? opc_beqz : opc_bnez,
                                         rand_bits(3) % 7, (rand_bits(1) + 1) * 2));
               end else begin
                  append_word(enc_imm(opc_addi, rand_bits(3) % 7, rand_bits(3) % 6 + 1,
                                      rand_bits(5)));
               end
            end
         endcase
      end
      append_word(16'h0000);
   endtask

   task automatic run_program(input string name);
      cur_name = name;
      @(negedge clk);
      rst_n = 1'b0;
      for (int c = 0; c < 16; c++) begin
         prog_we = (c < prog_len);
         prog_addr = 8'(c);
         prog_data = prog[c];
         @(negedge clk);
      end
      prog_we = 1'b0;
      exp_count = run_reference();
      exp_idx = 0;
      rst_n = 1'b1;
      while (!halted) begin
         @(negedge clk);
      end
      // Every write ahead of HALT has retired once HALT is in MEM/WB
      if (exp_idx != exp_count) begin
         other_errors++;
         $display("%s: halted rose with only %0d of %0d expected register writes retired",
                  name, exp_idx, exp_count);
      end
      repeat (8) @(negedge clk);
      if (halted !== 1'b1) begin
         other_errors++;
         $display("%s: halted dropped before the next reset", name);
      end
      if (err !== exp_err) begin
         value_errors++;
         $display("[FAIL] %0t %s: err is %b, expected %b", $time, name, err, exp_err);
      end
   endtask

   always @(posedge clk) begin
      if (rst_n && retire_valid) begin
         if (exp_idx >= exp_count) begin
            other_errors++;
            $display("%s: register write r%0d = %h retired after the last expected one",
                     cur_name, retire_reg, retire_data);
         end else if (retire_reg !== 3'(exp_reg[exp_idx]) ||
                      retire_data !== exp_val[exp_idx]) begin
            value_errors++;
            $display("[FAIL] %0t %s: write %0d is r%0d = %h, expected r%0d = %h", $time,
                     cur_name, exp_idx, retire_reg, retire_data, exp_reg[exp_idx],
                     exp_val[exp_idx]);
         end
         exp_idx++;
      end
   end

   always @(posedge clk) begin
      cycles++;
      if (cycles >= cycle_limit) begin
         $display("Timed out after %0d cycles, the processor never halted", cycles);
         $display("Test failures found");
         $finish;
      end
   end

   initial begin
      rst_n = 1'b0;
      prog_we = 1'b0;
      prog_addr = '0;
      prog_data = '0;
      lfsr = 32'hc45df02c;
      value_errors = 0;
      other_errors = 0;
      cycles = 0;
      exp_count = 0;
      exp_idx = 0;
      exp_err = 1'b0;
      cur_name = "reset";

      // Dependent ALU chain
      prog_len = 0;
      append_word(enc_imm(opc_addi, 0, 1, 5));
      append_word(enc_imm(opc_addi, 1, 2, 3));
      append_word(enc_alu(1, 2, 3, 0));
      append_word(enc_alu(3, 1, 4, 1));
      append_word(enc_alu(4, 2, 5, 2));
      append_word(enc_alu(5, 3, 6, 3));
      append_word(enc_imm(opc_subi, 6, 1, 7));
      append_word(enc_imm(opc_subi, 1, 2, -4));
      append_word(16'h0000);
      run_program("alu chain");

      // Fills words 0 to 7 of data memory for all later programs
      prog_len = 0;
      append_word(enc_imm(opc_addi, 0, 1, 9));
      append_word(enc_imm(opc_addi, 0, 2, -3));
      for (int a = 0; a < 8; a++) begin
         append_word(enc_imm(opc_st, 0, (a % 2) + 1, a * 2));
      end
      append_word(enc_imm(opc_ld, 0, 3, 2));
      append_word(enc_imm(opc_ld, 0, 4, 0));
      append_word(enc_imm(opc_ld, 0, 5, 14));
      append_word(16'h0000);
      run_program("load store");

      prog_len = 0;
      append_word(enc_imm(opc_addi, 0, 1, 0));
      append_word(enc_branch(opc_beqz, 1, 2));
      append_word(enc_imm(opc_addi, 0, 2, 1));
      append_word(enc_branch(opc_bnez, 1, 2));
      append_word(enc_imm(opc_addi, 0, 3, 2));
      append_word(enc_imm(opc_addi, 0, 4, 3));
      append_word(enc_branch(opc_bnez, 4, 2));
      append_word(enc_imm(opc_addi, 0, 5, 4));
      append_word(enc_branch(opc_beqz, 4, 2));
      append_word(enc_jump(opc_j, 2));
      append_word(enc_imm(opc_addi, 0, 6, 5));
      append_word(enc_jump(opc_jal, 2));
      append_word(enc_imm(opc_addi, 0, 2, 7));
      append_word(enc_imm(opc_addi, 7, 3, 1));
      append_word(16'h0000);
      run_program("branches");

      prog_len = 0;
      append_word(enc_imm(opc_addi, 0, 1, 1));
      append_word(16'h0000);
      append_word(enc_imm(opc_addi, 0, 2, 2));
      append_word(enc_imm(opc_addi, 0, 3, 3));
      run_program("halt");

      prog_len = 0;
      append_word(enc_imm(opc_addi, 0, 1, 3));
      append_word(16'hf800);
      append_word(enc_imm(opc_addi, 1, 2, 1));
      append_word(16'h0000);
      run_program("illegal opcode");

      prog_len = 0;
      append_word(enc_imm(opc_ld, 0, 1, 3));
      append_word(16'h0000);
      run_program("odd load");

      for (int r = 0; r < rand_runs; r++) begin
         build_random();
         run_program($sformatf("random %0d", r));
      end

      $display("Checks done: %0d value errors, %0d other errors", value_errors, other_errors);
      if (value_errors == 0 && other_errors == 0) begin
         $display("All tests passed!");
      end else begin
         $display("Test failures found");
      end
      $finish;
   end

endmodule

// File: source/proc.sv
// Top level: pipeline stages, stage latches, hazard unit, sticky halted and err
`timescale 1ns/1ps
module proc (
   input  logic                                clk,
   input  logic                                rst_n,
   input  logic                                prog_we,
   input  logic [pipe_pkg::imem_addr_width-1:0] prog_addr,
   input  logic [isa_pkg::word_width-1:0]      prog_data,
   output logic                                retire_valid,
   output logic [isa_pkg::reg_idx_width-1:0]   retire_reg,
   output logic [isa_pkg::word_width-1:0]      retire_data,
   output logic                                halted,
   output logic                                err
);
   import isa_pkg::*;
   import pipe_pkg::*;

   if_id_t if_d, if_q;
   id_ex_t id_d, id_q;
   ex_mem_t ex_d, ex_q;
   mem_wb_t mem_d, mem_q;

   logic stall;
   logic flush;
   logic redirect;
   logic [word_width-1:0] redirect_pc;
   logic halt_seen;
   logic illegal;
   logic misaligned;
   logic [reg_idx_width-1:0] rs_idx;
   logic [reg_idx_width-1:0] rt_idx;
   logic rs_used;
   logic rt_used;
   // HALT position in ID/EX and EX/MEM
   logic [1:0] halt_pipe;

   fetch u_fetch (
      .clk, .rst_n, .prog_we, .prog_addr, .prog_data,
      .stall, .redirect, .redirect_pc, .halt_seen,
      .if_out(if_d)
   );

   pipe_latch #(.payload_t(if_id_t), .reset_value(if_id_bubble)) if_id_reg (
      .clk, .rst_n, .hold(stall), .bubble(flush), .d(if_d), .q(if_q)
   );

   decode u_decode (
      .clk, .rst_n, .if_in(if_q),
      .wb_en(mem_q.reg_write), .wb_reg(mem_q.dest), .wb_data(mem_q.result),
      .id_out(id_d), .rs_idx, .rt_idx, .rs_used, .rt_used, .halt_seen, .illegal
   );

   hazard_unit u_hazard (
      .rs_idx, .rt_idx, .rs_used, .rt_used,
      .ex_dest(id_q.dest), .ex_reg_write(id_q.reg_write),
      .mem_dest(ex_q.dest), .mem_reg_write(ex_q.reg_write),
      .redirect, .stall, .flush
   );

   pipe_latch #(.payload_t(id_ex_t), .reset_value('0)) id_ex_reg (
      .clk, .rst_n, .hold(1'b0), .bubble(stall | flush), .d(id_d), .q(id_q)
   );

   execute u_execute (
      .ex_in(id_q), .ex_out(ex_d), .redirect, .redirect_pc
   );

   pipe_latch #(.payload_t(ex_mem_t), .reset_value('0)) ex_mem_reg (
      .clk, .rst_n, .hold(1'b0), .bubble(1'b0), .d(ex_d), .q(ex_q)
   );

   memory_stage u_memory (
      .clk, .rst_n, .mem_in(ex_q), .wb_out(mem_d), .misaligned
   );

   pipe_latch #(.payload_t(mem_wb_t), .reset_value('0)) mem_wb_reg (
      .clk, .rst_n, .hold(1'b0), .bubble(1'b0), .d(mem_d), .q(mem_q)
   );

   assign retire_valid = mem_q.reg_write;
   assign retire_reg = mem_q.dest;
   assign retire_data = mem_q.result;

   // HALT leaves decode as a bubble, so its progress is tracked here
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         halt_pipe <= '0;
         halted <= 1'b0;
         err <= 1'b0;
      end else begin
         halt_pipe <= {halt_pipe[0], halt_seen & ~flush};
         halted <= halted | halt_pipe[1];
         err <= err | (illegal & ~flush) | misaligned;
      end
   end

   assert property (@(posedge clk) disable iff (!rst_n) halted |-> !retire_valid)
      else $error("proc: register write retired after halt");

endmodule

// File: source/memory_stage.sv
// Data memory, alignment check and writeback value select
`timescale 1ns/1ps
module memory_stage (
   input  logic              clk,
   input  logic              rst_n,
   input  pipe_pkg::ex_mem_t mem_in,
   output pipe_pkg::mem_wb_t wb_out,
   output logic              misaligned
);
   import isa_pkg::*;
   import pipe_pkg::*;

   logic [word_width-1:0] dmem [dmem_depth];
   logic [dmem_addr_width-1:0] word_addr;
   logic [word_width-1:0] load_data;

   assign word_addr = mem_in.alu_result[dmem_addr_width:1];
   assign misaligned = (mem_in.mem_read || mem_in.mem_write) && mem_in.alu_result[0];
   assign load_data = dmem[word_addr];

   // Misaligned stores are dropped
   always_ff @(posedge clk) begin
      if (rst_n && mem_in.mem_write && !misaligned) begin
         dmem[word_addr] <= mem_in.store_data;
      end
   end

   always_comb begin
      wb_out.dest = mem_in.dest;
      wb_out.reg_write = mem_in.reg_write;
      if (mem_in.link) begin
         wb_out.result = mem_in.pc_next;
      end else if (mem_in.mem_read) begin
         wb_out.result = load_data;
      end else begin
         wb_out.result = mem_in.alu_result;
      end
   end

endmodule

// File: source/execute.sv
// ALU, branch condition and branch or jump target
`timescale 1ns/1ps
module execute (
   input  pipe_pkg::id_ex_t               ex_in,
   output pipe_pkg::ex_mem_t              ex_out,
   output logic                           redirect,
   output logic [isa_pkg::word_width-1:0] redirect_pc
);
   import isa_pkg::*;
   import pipe_pkg::*;

   logic [word_width-1:0] operand_b;
   logic [word_width-1:0] alu_result;
   logic rs_zero;

   assign operand_b = ex_in.alu_src_imm ? ex_in.imm : ex_in.rt_val;

   // Subtraction is always rs minus the second operand
   always_comb begin
      case (ex_in.alu_op)
         alu_add: alu_result = ex_in.rs_val + operand_b;
         alu_sub: alu_result = ex_in.rs_val - operand_b;
         alu_xor: alu_result = ex_in.rs_val ^ operand_b;
         default: alu_result = ex_in.rs_val & operand_b;
      endcase
   end

   assign rs_zero = (ex_in.rs_val == '0);
   assign redirect = (ex_in.branch_eq && rs_zero) ||
                     (ex_in.branch_ne && !rs_zero) ||
                     ex_in.jump;
   assign redirect_pc = ex_in.pc_next + ex_in.imm;

   always_comb begin
      ex_out.alu_result = alu_result;
      ex_out.store_data = ex_in.rt_val;
      ex_out.pc_next = ex_in.pc_next;
      ex_out.dest = ex_in.dest;
      ex_out.reg_write = ex_in.reg_write;
      ex_out.mem_read = ex_in.mem_read;
      ex_out.mem_write = ex_in.mem_write;
      ex_out.link = ex_in.link;
   end

endmodule

// File: source/hazard_unit.sv
// Read-after-write stall detection and branch flush control
`timescale 1ns/1ps
module hazard_unit (
   input  logic [isa_pkg::reg_idx_width-1:0] rs_idx,
   input  logic [isa_pkg::reg_idx_width-1:0] rt_idx,
   input  logic                              rs_used,
   input  logic                              rt_used,
   input  logic [isa_pkg::reg_idx_width-1:0] ex_dest,
   input  logic                              ex_reg_write,
   input  logic [isa_pkg::reg_idx_width-1:0] mem_dest,
   input  logic                              mem_reg_write,
   input  logic                              redirect,
   output logic                              stall,
   output logic                              flush
);

   logic rs_conflict;
   logic rt_conflict;

   // Writeback is covered by the write-first register file
   assign rs_conflict = rs_used &&
                        ((ex_reg_write && ex_dest == rs_idx) ||
                         (mem_reg_write && mem_dest == rs_idx));
   assign rt_conflict = rt_used &&
                        ((ex_reg_write && ex_dest == rt_idx) ||
                         (mem_reg_write && mem_dest == rt_idx));

   // Flush wins because the stalled instruction is on the wrong path
   assign flush = redirect;
   assign stall = (rs_conflict || rt_conflict) && !redirect;

endmodule

// File: source/decode.sv
// Control decode, register file, immediate extension, destination select, illegal opcodes
`timescale 1ns/1ps
module decode (
   input  logic                              clk,
   input  logic                              rst_n,
   input  pipe_pkg::if_id_t                  if_in,
   input  logic                              wb_en,
   input  logic [isa_pkg::reg_idx_width-1:0] wb_reg,
   input  logic [isa_pkg::word_width-1:0]    wb_data,
   output pipe_pkg::id_ex_t                  id_out,
   output logic [isa_pkg::reg_idx_width-1:0] rs_idx,
   output logic [isa_pkg::reg_idx_width-1:0] rt_idx,
   output logic                              rs_used,
   output logic                              rt_used,
   output logic                              halt_seen,
   output logic                              illegal
);
   import isa_pkg::*;
   import pipe_pkg::*;

   logic [word_width-1:0] regs [reg_count];
   logic [word_width-1:0] instr;
   opcode_t opcode;
   logic [word_width-1:0] imm5;
   logic [word_width-1:0] imm8;
   logic [word_width-1:0] imm11;

   assign instr = if_in.instruction;
   assign opcode = opcode_t'(instr[opcode_lsb +: opcode_width]);
   assign rs_idx = instr[rs_lsb +: reg_idx_width];
   assign rt_idx = instr[rt_lsb +: reg_idx_width];

   assign imm5 = {{(word_width - imm5_width){instr[imm5_width-1]}}, instr[imm5_width-1:0]};
   assign imm8 = {{(word_width - imm8_width){instr[imm8_width-1]}}, instr[imm8_width-1:0]};
   assign imm11 = {{(word_width - imm11_width){instr[imm11_width-1]}}, instr[imm11_width-1:0]};

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         for (int i = 0; i < reg_count; i++) begin
            regs[i] <= '0;
         end
      end else if (wb_en) begin
         regs[wb_reg] <= wb_data;
      end
   end

   always_comb begin
      id_out = '0;
      // Write-first, so writeback never stalls
      id_out.rs_val = (wb_en && wb_reg == rs_idx) ? wb_data : regs[rs_idx];
      id_out.rt_val = (wb_en && wb_reg == rt_idx) ? wb_data : regs[rt_idx];
      id_out.pc_next = if_in.pc_next;
      id_out.dest = instr[rt_lsb +: reg_idx_width];
      rs_used = 1'b0;
      rt_used = 1'b0;
      halt_seen = 1'b0;
      illegal = 1'b0;
      case (opcode)
         op_halt: halt_seen = 1'b1;
         op_nop: begin
         end
         op_addi, op_subi, op_ld: begin
            rs_used = 1'b1;
            id_out.reg_write = 1'b1;
            id_out.alu_src_imm = 1'b1;
            id_out.imm = imm5;
            id_out.mem_read = (opcode == op_ld);
            id_out.alu_op = (opcode == op_subi) ? alu_sub : alu_add;
         end
         op_st: begin
            rs_used = 1'b1;
            rt_used = 1'b1;
            id_out.mem_write = 1'b1;
            id_out.alu_src_imm = 1'b1;
            id_out.imm = imm5;
         end
         op_beqz, op_bnez: begin
            rs_used = 1'b1;
            id_out.imm = imm8;
            id_out.branch_eq = (opcode == op_beqz);
            id_out.branch_ne = (opcode == op_bnez);
         end
         op_j, op_jal: begin
            id_out.imm = imm11;
            id_out.jump = 1'b1;
            id_out.link = (opcode == op_jal);
            id_out.reg_write = (opcode == op_jal);
            id_out.dest = link_reg;
         end
         op_alu: begin
            rs_used = 1'b1;
            rt_used = 1'b1;
            id_out.reg_write = 1'b1;
            id_out.alu_op = alu_op_t'(instr[func_lsb +: 2]);
            id_out.dest = instr[rd_lsb +: reg_idx_width];
         end
         default: illegal = 1'b1;
      endcase
   end

endmodule

// File: source/fetch.sv
// Program counter, instruction memory with program load port, redirect and halt freeze
`timescale 1ns/1ps
module fetch (
   input  logic                                clk,
   input  logic                                rst_n,
   input  logic                                prog_we,
   input  logic [pipe_pkg::imem_addr_width-1:0] prog_addr,
   input  logic [isa_pkg::word_width-1:0]      prog_data,
   input  logic                                stall,
   input  logic                                redirect,
   input  logic [isa_pkg::word_width-1:0]      redirect_pc,
   input  logic                                halt_seen,
   output pipe_pkg::if_id_t                    if_out
);
   import isa_pkg::*;
   import pipe_pkg::*;

   logic [word_width-1:0] imem [imem_depth];
   logic [word_width-1:0] pc;
   logic frozen;
   logic halt_now;

   // HALT on a flushed path does not count
   assign halt_now = halt_seen & ~redirect;

   // Program load only while the core is held in reset
   always_ff @(posedge clk) begin
      if (!rst_n && prog_we) begin
         imem[prog_addr] <= prog_data;
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         pc <= '0;
         frozen <= 1'b0;
      end else begin
         if (redirect) begin
            pc <= redirect_pc;
         end else if (!(stall || frozen || halt_now)) begin
            pc <= pc + word_width'(2);
         end
         if (halt_now) begin
            frozen <= 1'b1;
         end
      end
   end

   always_comb begin
      if_out.pc_next = pc + word_width'(2);
      if_out.instruction = (frozen || halt_now) ? nop_word : imem[pc[imem_addr_width:1]];
   end

   // Branch and jump targets come from execute
   assert property (@(posedge clk) disable iff (!rst_n) pc[0] == 1'b0)
      else $error("fetch: odd program counter %h", pc);

endmodule

// File: source/pipe_latch.sv
// Pipeline register with hold and bubble, generic over the payload type
`timescale 1ns/1ps
module pipe_latch #(
   parameter type payload_t = logic,
   parameter payload_t reset_value = '0
) (
   input  logic     clk,
   input  logic     rst_n,
   input  logic     hold,
   input  logic     bubble,
   input  payload_t d,
   output payload_t q
);

   always_ff @(posedge clk) begin
      if (!rst_n || bubble) begin
         q <= reset_value;
      end else if (!hold) begin
         q <= d;
      end
   end

   // Priority between stall and flush is settled before the latch
   assert property (@(posedge clk) disable iff (!rst_n) !(hold && bubble))
      else $error("pipe_latch: hold and bubble both high");

endmodule

// File: source/pipe_pkg.sv
// Memory sizes and the four pipeline stage payload structs
package pipe_pkg;

   localparam int imem_depth = 256;
   localparam int dmem_depth = 256;
   localparam int imem_addr_width = 8;
   localparam int dmem_addr_width = 8;

   typedef struct packed {
      logic [isa_pkg::word_width-1:0] instruction;
      logic [isa_pkg::word_width-1:0] pc_next;
   } if_id_t;

   typedef struct packed {
      logic [isa_pkg::word_width-1:0] rs_val;
      logic [isa_pkg::word_width-1:0] rt_val;
      logic [isa_pkg::word_width-1:0] imm;
      logic [isa_pkg::word_width-1:0] pc_next;
      logic [isa_pkg::reg_idx_width-1:0] dest;
      logic reg_write;
      logic mem_read;
      logic mem_write;
      logic link;
      isa_pkg::alu_op_t alu_op;
      logic alu_src_imm;
      logic branch_eq;
      logic branch_ne;
      logic jump;
   } id_ex_t;

   typedef struct packed {
      logic [isa_pkg::word_width-1:0] alu_result;
      logic [isa_pkg::word_width-1:0] store_data;
      logic [isa_pkg::word_width-1:0] pc_next;
      logic [isa_pkg::reg_idx_width-1:0] dest;
      logic reg_write;
      logic mem_read;
      logic mem_write;
      logic link;
   } ex_mem_t;

   typedef struct packed {
      logic [isa_pkg::word_width-1:0] result;
      logic [isa_pkg::reg_idx_width-1:0] dest;
      logic reg_write;
   } mem_wb_t;

   // Empty fetch slot decodes as a NOP
   localparam if_id_t if_id_bubble = '{instruction: isa_pkg::nop_word, pc_next: '0};

endpackage

// File: source/isa_pkg.sv
// Opcodes, instruction field positions, ALU operation codes and register file size
package isa_pkg;

   localparam int word_width = 16;
   localparam int reg_count = 8;
   localparam int reg_idx_width = 3;
   localparam logic [reg_idx_width-1:0] link_reg = 3'd7;

   localparam int opcode_width = 5;

   typedef enum logic [opcode_width-1:0] {
      op_halt = 5'b00000,
      op_nop  = 5'b00001,
      op_j    = 5'b00100,
      op_jal  = 5'b00110,
      op_addi = 5'b01000,
      op_subi = 5'b01001,
      op_beqz = 5'b01100,
      op_bnez = 5'b01101,
      op_st   = 5'b10000,
      op_ld   = 5'b10001,
      op_alu  = 5'b11011
   } opcode_t;

   // Function field of the register ALU group
   typedef enum logic [1:0] {alu_add, alu_sub, alu_xor, alu_and} alu_op_t;

   // Field positions
   localparam int opcode_lsb = 11;
   localparam int rs_lsb = 8;
   localparam int rt_lsb = 5;
   localparam int rd_lsb = 2;
   localparam int func_lsb = 0;
   localparam int imm5_width = 5;
   localparam int imm8_width = 8;
   localparam int imm11_width = 11;

   localparam logic [word_width-1:0] nop_word = {op_nop, {opcode_lsb{1'b0}}};

endpackage
